/* bru_sched_pkg.sv */
// Sizes allow at most 8 scheduler entries and at most 16 branches in flight between flushes
package bru_sched_pkg;

  // --------------------
  // Sizes
  localparam int CMT_ID_W    = 5;   // Top bit is the wrap bit
  localparam int RNID_W      = 6;
  localparam int PHY_WR_NUM  = 2;
  localparam int ENTRY_IDX_W = 3;   // Index of an entry inside the queue

  typedef logic [RNID_W-1:0]   rnid_t;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;

  // --------------------
  // Instruction as dispatched
  typedef struct packed {
    logic       valid;
    rnid_t      rnid;
    logic       ready;           // Written back, safe to read
    logic [1:0] predict_ready;   // Early load wake-up, two cycle window
  } src_t;

  typedef struct packed {
    cmt_id_t     cmt_id;
    src_t [1:0]  src;
    logic [15:0] payload;        // Opcode, immediate and target
    logic        dead;
  } disp_t;

  // --------------------
  // Wake-up, flush and issue buses
  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } phy_wr_t;

  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } early_wr_t;

  typedef struct packed {
    logic  valid;
    rnid_t rnid;                 // Load destination that missed
  } mispred_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;             // Branch itself survives
  } br_flush_t;

  typedef struct packed {
    logic                   valid;
    cmt_id_t                cmt_id;
    logic [15:0]            payload;
    logic [ENTRY_IDX_W-1:0] entry_idx;
  } issue_t;

  typedef enum logic [1:0] {INIT, WAIT, ISSUED, SCHED_CLEAR} sched_state_t;

  // True when a was allocated after b
  function automatic logic is_younger(input cmt_id_t a, input cmt_id_t b);
    logic same_wrap;
    same_wrap = (a[CMT_ID_W-1] == b[CMT_ID_W-1]);
    if (same_wrap) begin
      return a[CMT_ID_W-2:0] > b[CMT_ID_W-2:0];
    end
    return a[CMT_ID_W-2:0] < b[CMT_ID_W-2:0];  // a has wrapped past b
  endfunction

endpackage

/* bru_wakeup_match.sv */
// Purely combinational; each hit is qualified only by the valid bit of its own bus
`timescale 1ns/1ps

module bru_wakeup_match (
  input  bru_sched_pkg::rnid_t     i_rnid,
  input  bru_sched_pkg::phy_wr_t   i_phy_wr [bru_sched_pkg::PHY_WR_NUM],
  input  bru_sched_pkg::early_wr_t i_early_wr,
  input  bru_sched_pkg::mispred_t  i_mispred,
  output logic                     o_phy_hit,
  output logic                     o_early_hit,
  output logic                     o_mispred_hit
);

  import bru_sched_pkg::*;

  logic [PHY_WR_NUM-1:0] w_phy_port_hit;

  // --------------------
  // Write bus, any port
  always_comb begin
    for (int i = 0; i < PHY_WR_NUM; i++) begin
      w_phy_port_hit[i] = i_phy_wr[i].valid & (i_phy_wr[i].rnid == i_rnid);
    end
  end

  assign o_phy_hit = |w_phy_port_hit;

  // --------------------
  // Speculative load path
  assign o_early_hit   = i_early_wr.valid & (i_early_wr.rnid == i_rnid);  // Wake early
  assign o_mispred_hit = i_mispred.valid & (i_mispred.rnid == i_rnid);    // Take it back

endmodule

/* bru_issue_entry.sv */
// Put must only target an entry in INIT; the entry frees itself one cycle after a clean issue
`timescale 1ns/1ps

module bru_issue_entry (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_put,
  input  bru_sched_pkg::disp_t      i_put_data,
  input  bru_sched_pkg::phy_wr_t    i_phy_wr [bru_sched_pkg::PHY_WR_NUM],
  input  bru_sched_pkg::early_wr_t  i_early_wr,
  input  bru_sched_pkg::mispred_t   i_mispred,
  input  bru_sched_pkg::br_flush_t  i_br_flush,
  input  logic                      i_commit_flush,
  input  logic                      i_entry_picked,
  output logic                      o_entry_valid,
  output logic                      o_entry_ready,
  output bru_sched_pkg::cmt_id_t    o_cmt_id,
  output bru_sched_pkg::disp_t      o_entry_data,
  output logic                      o_replay
);

  import bru_sched_pkg::*;

  sched_state_t r_state;
  sched_state_t w_state_next;
  disp_t        r_entry;
  disp_t        w_entry_next;
  disp_t        w_init_entry;

  rnid_t      w_rs_rnid [2];
  logic [1:0] w_rs_valid;
  logic [1:0] w_rs_phy_hit;
  logic [1:0] w_rs_early_hit;
  logic [1:0] w_rs_mispred_hit;
  logic [1:0] w_rs_pred_mispred;  // Source woke on a load that missed
  logic       w_any_pred_mispred;

  logic w_entry_flush;
  logic w_put_kill;

  // Source not needed, written, or inside its early window
  function automatic logic src_usable(input src_t src);
    return !src.valid | src.ready | (|src.predict_ready);
  endfunction

  // --------------------
  // Tag compare per source
  for (genvar rs = 0; rs < 2; rs++) begin : g_rs
    // Incoming tags are checked in the put cycle
    assign w_rs_rnid[rs]  = i_put ? i_put_data.src[rs].rnid  : r_entry.src[rs].rnid;
    assign w_rs_valid[rs] = i_put ? i_put_data.src[rs].valid : r_entry.src[rs].valid;

    bru_wakeup_match u_match (
      .i_rnid        (w_rs_rnid[rs]),
      .i_phy_wr      (i_phy_wr),
      .i_early_wr    (i_early_wr),
      .i_mispred     (i_mispred),
      .o_phy_hit     (w_rs_phy_hit[rs]),
      .o_early_hit   (w_rs_early_hit[rs]),
      .o_mispred_hit (w_rs_mispred_hit[rs])
    );

    // A source already written cannot be taken back
    assign w_rs_pred_mispred[rs] = r_entry.src[rs].valid & ~r_entry.src[rs].ready &
                                   (|r_entry.src[rs].predict_ready) & w_rs_mispred_hit[rs];
  end

  assign w_any_pred_mispred = |w_rs_pred_mispred;

  // --------------------
  // Flush and kill
  assign w_entry_flush = o_entry_valid &
                         (i_commit_flush |
                          (i_br_flush.valid & is_younger(r_entry.cmt_id, i_br_flush.cmt_id)));

  assign w_put_kill = i_put_data.dead | i_commit_flush |
                      (i_br_flush.valid & is_younger(i_put_data.cmt_id, i_br_flush.cmt_id));

  // Entry contents as loaded at put
  always_comb begin
    w_init_entry = i_put_data;
    for (int rs = 0; rs < 2; rs++) begin
      w_init_entry.src[rs].ready         = i_put_data.src[rs].ready |
                                           (w_rs_valid[rs] & w_rs_phy_hit[rs]);
      w_init_entry.src[rs].predict_ready = {1'b0, w_rs_valid[rs] & w_rs_early_hit[rs]};
    end
  end

  // --------------------
  // Next state
  always_comb begin
    w_state_next = r_state;
    w_entry_next = r_entry;

    for (int rs = 0; rs < 2; rs++) begin
      w_entry_next.src[rs].ready = r_entry.src[rs].ready | (w_rs_valid[rs] & w_rs_phy_hit[rs]);
      if (w_rs_pred_mispred[rs]) begin
        w_entry_next.src[rs].predict_ready = 2'b00;  // Early window closed by the miss
      end else begin
        w_entry_next.src[rs].predict_ready = {r_entry.src[rs].predict_ready[0],
                                              w_rs_valid[rs] & w_rs_early_hit[rs]};
      end
    end

    case (r_state)
      INIT: begin
        if (i_put) begin
          w_entry_next = w_init_entry;
          w_state_next = w_put_kill ? SCHED_CLEAR : WAIT;
        end
      end
      WAIT: begin
        if (w_entry_flush) begin
          w_state_next = INIT;
        end else if (o_entry_ready & i_entry_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        if (w_entry_flush) begin
          w_state_next = INIT;
        end else if (w_any_pred_mispred) begin
          w_state_next = WAIT;  // Replay, wait for the real write
          w_entry_next.src[0].predict_ready = 2'b00;
          w_entry_next.src[1].predict_ready = 2'b00;
        end else begin
          w_state_next = SCHED_CLEAR;
        end
      end
      SCHED_CLEAR: begin
        w_state_next = INIT;
      end
      default: begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    r_entry <= w_entry_next;
  end

  // --------------------
  // Outputs
  assign o_entry_valid = (r_state != INIT);
  assign o_entry_ready = (r_state == WAIT) & !w_entry_flush & !w_any_pred_mispred &
                         src_usable(r_entry.src[0]) & src_usable(r_entry.src[1]);
  assign o_cmt_id      = r_entry.cmt_id;
  assign o_entry_data  = r_entry;
  assign o_replay      = (r_state == ISSUED) & w_any_pred_mispred;  // Same cycle as o_issue

endmodule

/* bru_entry_alloc.sv */
// Lowest free entry wins; a dispatch while no entry is free is dropped without back-pressure
`timescale 1ns/1ps

module bru_entry_alloc #(
  parameter int ENTRY_NUM = 4
) (
  input  logic                 i_disp_valid,
  input  logic [ENTRY_NUM-1:0] i_entry_valid,
  output logic [ENTRY_NUM-1:0] o_put,
  output logic                 o_disp_ready
);

  logic [ENTRY_NUM-1:0] w_free;
  logic [ENTRY_NUM-1:0] w_first_free;

  assign w_free = ~i_entry_valid;

  // Priority encoder, index 0 first
  always_comb begin
    logic found;
    w_first_free = '0;
    found        = 1'b0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (w_free[i] && !found) begin
        w_first_free[i] = 1'b1;
        found           = 1'b1;
      end
    end
  end

  assign o_put        = i_disp_valid ? w_first_free : '0;  // One-hot or empty
  assign o_disp_ready = |w_free;

endmodule

/* bru_issue_select.sv */
// Ready entries must hold distinct commit ids less than half the wrap range apart
`timescale 1ns/1ps

module bru_issue_select #(
  parameter int ENTRY_NUM = 4
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic [ENTRY_NUM-1:0]   i_entry_ready,
  input  bru_sched_pkg::cmt_id_t i_cmt_id     [ENTRY_NUM],
  input  bru_sched_pkg::disp_t   i_entry_data [ENTRY_NUM],
  output logic [ENTRY_NUM-1:0]   o_picked,
  output bru_sched_pkg::issue_t  o_issue
);

  import bru_sched_pkg::*;

  logic [ENTRY_NUM-1:0]   w_older [ENTRY_NUM];  // Row i, column j: i not younger than j
  logic                   w_any_picked;
  cmt_id_t                w_pick_cmt_id;
  logic [15:0]            w_pick_payload;
  logic [ENTRY_IDX_W-1:0] w_pick_idx;

  logic                   r_issue_valid;
  cmt_id_t                r_issue_cmt_id;
  logic [15:0]            r_issue_payload;
  logic [ENTRY_IDX_W-1:0] r_issue_idx;

  // --------------------
  // Age matrix
  always_comb begin
    for (int i = 0; i < ENTRY_NUM; i++) begin
      for (int j = 0; j < ENTRY_NUM; j++) begin
        w_older[i][j] = (i == j) | is_younger(i_cmt_id[j], i_cmt_id[i]);
      end
    end
  end

  // Oldest among the ready ones
  for (genvar i = 0; i < ENTRY_NUM; i++) begin : g_pick
    assign o_picked[i] = i_entry_ready[i] & (&(w_older[i] | ~i_entry_ready));
  end

  assign w_any_picked = |o_picked;

  always_comb begin
    w_pick_cmt_id  = '0;
    w_pick_payload = '0;
    w_pick_idx     = '0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (o_picked[i]) begin
        w_pick_cmt_id  = i_entry_data[i].cmt_id;
        w_pick_payload = i_entry_data[i].payload;
        w_pick_idx     = ENTRY_IDX_W'(i);
      end
    end
  end

  // --------------------
  // Issue register
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_issue_valid <= 1'b0;
    end else begin
      r_issue_valid <= w_any_picked;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_any_picked) begin
      r_issue_cmt_id  <= w_pick_cmt_id;
      r_issue_payload <= w_pick_payload;
      r_issue_idx     <= w_pick_idx;
    end
  end

  always_comb begin
    o_issue.valid     = r_issue_valid;
    o_issue.cmt_id    = r_issue_cmt_id;
    o_issue.payload   = r_issue_payload;
    o_issue.entry_idx = r_issue_idx;
  end

endmodule

/* bru_scheduler.sv */
// Driver holds i_disp_valid low while o_disp_ready is low; ENTRY_NUM is limited to 8
`timescale 1ns/1ps

module bru_scheduler #(
  parameter int ENTRY_NUM = 4
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_disp_valid,
  input  bru_sched_pkg::disp_t      i_disp,
  output logic                      o_disp_ready,
  input  bru_sched_pkg::phy_wr_t    i_phy_wr [bru_sched_pkg::PHY_WR_NUM],
  input  bru_sched_pkg::early_wr_t  i_early_wr,
  input  bru_sched_pkg::mispred_t   i_mispred,
  input  bru_sched_pkg::br_flush_t  i_br_flush,
  input  logic                      i_commit_flush,
  output bru_sched_pkg::issue_t     o_issue,
  output logic                      o_issue_cancel
);

  import bru_sched_pkg::*;

  logic [ENTRY_NUM-1:0] w_put;
  logic [ENTRY_NUM-1:0] w_entry_valid;
  logic [ENTRY_NUM-1:0] w_entry_ready;
  logic [ENTRY_NUM-1:0] w_picked;
  logic [ENTRY_NUM-1:0] w_replay;
  cmt_id_t              w_cmt_id     [ENTRY_NUM];
  disp_t                w_entry_data [ENTRY_NUM];

  bru_entry_alloc #(.ENTRY_NUM(ENTRY_NUM)) u_alloc (
    .i_disp_valid  (i_disp_valid),
    .i_entry_valid (w_entry_valid),
    .o_put         (w_put),
    .o_disp_ready  (o_disp_ready)
  );

  for (genvar e = 0; e < ENTRY_NUM; e++) begin : g_entry
    bru_issue_entry u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_put          (w_put[e]),
      .i_put_data     (i_disp),
      .i_phy_wr       (i_phy_wr),
      .i_early_wr     (i_early_wr),
      .i_mispred      (i_mispred),
      .i_br_flush     (i_br_flush),
      .i_commit_flush (i_commit_flush),
      .i_entry_picked (w_picked[e]),
      .o_entry_valid  (w_entry_valid[e]),
      .o_entry_ready  (w_entry_ready[e]),
      .o_cmt_id       (w_cmt_id[e]),
      .o_entry_data   (w_entry_data[e]),
      .o_replay       (w_replay[e])
    );
  end

  bru_issue_select #(.ENTRY_NUM(ENTRY_NUM)) u_select (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_entry_ready (w_entry_ready),
    .i_cmt_id      (w_cmt_id),
    .i_entry_data  (w_entry_data),
    .o_picked      (w_picked),
    .o_issue       (o_issue)
  );

  // At most one entry sits in ISSUED at a time
  assign o_issue_cancel = |w_replay;

endmodule

/* tb_bru_scheduler.sv */
// Drives on the falling edge with the DUT at 4 entries; commit ids stay within 8 of each other
`timescale 1ns/1ps

module tb_bru_scheduler;

  import bru_sched_pkg::*;

  localparam int ENTRY_NUM = 4;
  localparam int TIMEOUT   = 50;   // Cycles allowed for any single wait

  logic      i_clk;
  logic      i_reset_n;
  logic      i_disp_valid;
  disp_t     i_disp;
  logic      o_disp_ready;
  phy_wr_t   i_phy_wr [PHY_WR_NUM];
  early_wr_t i_early_wr;
  mispred_t  i_mispred;
  br_flush_t i_br_flush;
  logic      i_commit_flush;
  issue_t    o_issue;
  logic      o_issue_cancel;

  int                     seed = 74742;
  logic [15:0]            disp_payload [32];   // Payload last dispatched per commit id
  cmt_id_t                exp_cmt_q [$];       // Expected issue order
  logic [15:0]            exp_payload_q [$];
  logic [ENTRY_IDX_W-1:0] exp_idx_q [$];       // Entry the instruction was put into

  bru_scheduler #(.ENTRY_NUM(ENTRY_NUM)) uut (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // --------------------
  // Helpers
  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic step();
    @(negedge i_clk);
  endtask

  task automatic clear_buses();
    for (int p = 0; p < PHY_WR_NUM; p++) begin
      i_phy_wr[p] = '0;
    end
    i_early_wr     = '0;
    i_mispred      = '0;
    i_br_flush     = '0;
    i_commit_flush = 1'b0;
  endtask

  function automatic src_t make_src(input logic valid, input rnid_t rnid, input logic ready);
    src_t s;
    s       = '0;
    s.valid = valid;
    s.rnid  = rnid;
    s.ready = ready;
    return s;
  endfunction

  // One-cycle dispatch once an entry is free
  task automatic dispatch(input cmt_id_t cmt, input src_t s0, input src_t s1, input logic dead);
    int wait_cnt;
    wait_cnt = 0;
    while (!o_disp_ready) begin
      step();
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        $display("Timeout: no scheduler entry became free for commit id %0d", cmt);
        abort_run();
      end
    end
    disp_payload[cmt] = 16'($random(seed));
    i_disp_valid      = 1'b1;
    i_disp.cmt_id     = cmt;
    i_disp.src[0]     = s0;
    i_disp.src[1]     = s1;
    i_disp.payload    = disp_payload[cmt];
    i_disp.dead       = dead;
    step();
    i_disp_valid = 1'b0;
  endtask

  // Entry index is the lowest entry that was free in the dispatch cycle
  task automatic expect_issue(input cmt_id_t cmt, input int idx);
    exp_cmt_q.push_back(cmt);
    exp_payload_q.push_back(disp_payload[cmt]);
    exp_idx_q.push_back(ENTRY_IDX_W'(idx));
  endtask

  task automatic wait_issue(input string name);
    int wait_cnt;
    wait_cnt = 0;
    while (!o_issue.valid) begin
      step();
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        $display("Timeout: no instruction issued in %s", name);
        abort_run();
      end
    end
  endtask

  // Scoreboard compare against the current o_issue
  task automatic check_issue_now(input string name);
    cmt_id_t                exp_cmt;
    logic [15:0]            exp_pl;
    logic [ENTRY_IDX_W-1:0] exp_idx;
    if (exp_cmt_q.size() == 0) begin
      $display("Unexpected issue seen in %s", name);
      abort_run();
    end
    exp_cmt = exp_cmt_q.pop_front();
    exp_pl  = exp_payload_q.pop_front();
    exp_idx = exp_idx_q.pop_front();
    check_eq({name, " valid"}, 1, o_issue.valid);
    check_eq({name, " cmt_id"}, exp_cmt, o_issue.cmt_id);
    check_eq({name, " payload"}, exp_pl, o_issue.payload);
    check_eq({name, " entry_idx"}, exp_idx, o_issue.entry_idx);
  endtask

  task automatic check_next_issue(input string name);
    wait_issue(name);
    check_issue_now(name);
    check_eq({name, " cancel"}, 0, o_issue_cancel);
    step();
  endtask

  task automatic no_issue_for(input string name, input int cycles);
    repeat (cycles) begin
      check_eq({name, " valid"}, 0, o_issue.valid);
      check_eq({name, " cancel"}, 0, o_issue_cancel);
      step();
    end
  endtask

  task automatic wait_disp_ready(input string name);
    int wait_cnt;
    wait_cnt = 0;
    while (!o_disp_ready) begin
      step();
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        $display("Timeout: dispatch ready never returned in %s", name);
        abort_run();
      end
    end
  endtask

  // --------------------
  // Stimulus
  initial begin
    rnid_t tag;
    i_reset_n    = 1'b0;
    i_disp_valid = 1'b0;
    i_disp       = '0;
    clear_buses();
    repeat (10) @(posedge i_clk);
    step();
    i_reset_n = 1'b1;
    check_eq("reset issue", 0, o_issue.valid);
    check_eq("reset cancel", 0, o_issue_cancel);
    check_eq("reset disp_ready", 1, o_disp_ready);

    // Ready at dispatch, issue exactly two cycles later
    for (int n = 0; n < 3; n++) begin
      dispatch(cmt_id_t'(n), make_src(1'b1, rnid_t'($random(seed)), 1'b1), '0, 1'b0);
      expect_issue(cmt_id_t'(n), n % 2);   // Previous entry still clearing
      check_eq("latency early", 0, o_issue.valid);
      step();
      check_issue_now("latency");
      step();
    end
    tag         = rnid_t'($random(seed));
    i_phy_wr[1] = {1'b1, tag};   // Write seen in the put cycle
    dispatch(5'd3, make_src(1'b1, tag, 1'b0), '0, 1'b0);
    i_phy_wr[1] = '0;
    expect_issue(5'd3, 1);
    check_eq("put write early", 0, o_issue.valid);
    step();
    check_issue_now("put write latency");
    step();
    no_issue_for("latency idle", 4);

    // Tag wake-up, full queue, age order across the wrap
    dispatch(5'd16, make_src(1'b1, 6'd10, 1'b0), '0, 1'b0);
    dispatch(5'd14, make_src(1'b1, 6'd10, 1'b0), '0, 1'b0);
    dispatch(5'd17, '0, make_src(1'b1, 6'd11, 1'b0), 1'b0);
    dispatch(5'd15, make_src(1'b1, 6'd10, 1'b0), make_src(1'b1, 6'd12, 1'b1), 1'b0);
    check_eq("queue full", 0, o_disp_ready);
    no_issue_for("tag waiting", 5);
    i_phy_wr[0] = {1'b1, 6'd11};
    step();
    clear_buses();
    expect_issue(5'd17, 2);
    check_next_issue("single wake");
    wait_disp_ready("free after issue");
    i_phy_wr[1] = {1'b1, 6'd10};
    step();
    clear_buses();
    expect_issue(5'd14, 1);
    expect_issue(5'd15, 3);
    expect_issue(5'd16, 0);
    repeat (3) check_next_issue("age order");
    no_issue_for("age drained", 4);

    // Early wake-up, miss, replay
    dispatch(5'd18, make_src(1'b1, 6'd20, 1'b0), '0, 1'b0);
    no_issue_for("early waiting", 3);
    i_early_wr = {1'b1, 6'd20};
    step();
    clear_buses();
    expect_issue(5'd18, 0);
    wait_issue("early wake");
    check_issue_now("early wake");
    i_mispred = {1'b1, 6'd20};   // Load missed in the issue cycle
    #1;
    check_eq("early cancel", 1, o_issue_cancel);
    step();
    clear_buses();
    no_issue_for("replay waiting", 5);
    i_phy_wr[0] = {1'b1, 6'd20};
    step();
    clear_buses();
    expect_issue(5'd18, 0);
    check_next_issue("replay reissue");
    no_issue_for("replay done", 4);

    // Branch flush kills younger, incl. a put in the flush cycle
    dispatch(5'd19, make_src(1'b1, 6'd30, 1'b0), '0, 1'b0);
    dispatch(5'd21, make_src(1'b1, 6'd30, 1'b0), '0, 1'b0);
    dispatch(5'd22, '0, make_src(1'b1, 6'd30, 1'b0), 1'b0);
    i_br_flush = {1'b1, 5'd20};
    dispatch(5'd23, '0, '0, 1'b0);
    clear_buses();
    i_phy_wr[0] = {1'b1, 6'd30};
    step();
    clear_buses();
    expect_issue(5'd19, 0);
    check_next_issue("branch flush older");
    no_issue_for("branch flush younger", 6);

    // Dead dispatch and commit flush
    dispatch(5'd24, '0, '0, 1'b1);
    no_issue_for("dead dispatch", 5);
    dispatch(5'd25, make_src(1'b1, 6'd31, 1'b0), '0, 1'b0);
    dispatch(5'd26, make_src(1'b1, 6'd31, 1'b0), make_src(1'b1, 6'd32, 1'b1), 1'b0);
    i_commit_flush = 1'b1;
    step();
    clear_buses();
    i_phy_wr[1] = {1'b1, 6'd31};
    step();
    clear_buses();
    no_issue_for("commit flush", 6);
    dispatch(5'd27, '0, '0, 1'b0);
    expect_issue(5'd27, 0);
    check_next_issue("after commit flush");

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* list.f */
bru_sched_pkg.sv
bru_wakeup_match.sv
bru_issue_entry.sv
bru_entry_alloc.sv
bru_issue_select.sv
bru_scheduler.sv
tb_bru_scheduler.sv
